// ==== rtl/fruPkg.sv ====
// Forwarding register unit definitions

package fruPkg;

   ////////////////////////////////////////
   // widths and sizes
   ////////////////////////////////////////

   localparam int dataWidth     = 32;  // operand and result buses
   localparam int regCount      = 32;  // entries in the register file
   localparam int regIndexWidth = 5;   // bits needed to index regCount
   localparam int regAddrWidth  = 6;   // msb is the valid bit, low bits the index

   ////////////////////////////////////////
   // hardwired zero register
   ////////////////////////////////////////

   localparam logic [regIndexWidth-1:0] zeroRegIndex = 5'd31;  // r31, never forwarded
   localparam logic [dataWidth-1:0]     zeroRegValue = '0;     // what r31 reads as

   // class of the instruction entering the execute stage
   // only a load leaves a result that the execute stage cannot forward yet
   typedef enum logic [2:0] {
      opNop    = 3'd0,  // bubble
      opAlu    = 3'd1,  // result ready at end of execute
      opLoad   = 3'd2,  // result ready only after memory access
      opStore  = 3'd3,  // no register result, address calc only
      opBranch = 3'd4   // resolves in execute
   } instrClass_t;

   // source of an operand at the forwarding mux
   // codes follow stage age, the youngest producer gets the highest code
   typedef enum logic [1:0] {
      selReg = 2'b00,  // register file read
      selWb  = 2'b01,  // latched writeback entry
      selMau = 2'b10,  // memory stage output
      selExu = 2'b11   // execute stage result
   } fwdSel_t;

endpackage

// ==== rtl/pipeMirror.sv ====
// Pipeline stage mirror

module pipeMirror
   import fruPkg::*;
(
   input  logic                    sys_clk,
   input  logic                    rst,
   // stage control levels from the pipeline controller
   input  logic                    stepExu,      // execute stage advances next edge
   input  logic                    stepWb,       // writeback stage advances next edge
   input  logic                    workExu,      // execute stage holds valid work
   input  logic                    workMau,      // memory stage holds valid work
   input  logic                    workWb,       // writeback stage holds valid work
   input  logic                    exuCond,      // low iff a cmov failed in execute
   input  logic                    mauCond,      // low iff a cmov failed in memory
   // addresses, msb is the valid bit
   input  logic [regAddrWidth-1:0] regA,
   input  logic [regAddrWidth-1:0] regB,
   input  logic [regAddrWidth-1:0] exuDest,
   input  logic [regAddrWidth-1:0] mauDest,
   // result buses
   input  logic [dataWidth-1:0]    exuResData,
   input  logic [dataWidth-1:0]    mauData,
   input  instrClass_t             decode,       // class of instr entering execute
   // registered copies, stable for the whole cycle
   output logic                    lWorkExu,
   output logic                    lWorkMau,
   output logic                    lWorkWb,
   output logic                    lExuCond,
   output logic                    lMauCond,
   output logic [regAddrWidth-1:0] lRegA,
   output logic [regAddrWidth-1:0] lRegB,
   output logic [regAddrWidth-1:0] lExuDest,
   output logic [regAddrWidth-1:0] lMauDest,
   output logic [dataWidth-1:0]    lExuResData,
   output logic [dataWidth-1:0]    lMauData,
   // mirror state
   output logic                    exuIsLoad,    // execute stage holds a load
   output logic [regAddrWidth-1:0] wbAddr,       // writeback destination with valid bit
   output logic [dataWidth-1:0]    wbData,       // writeback result
   output logic                    wbCond        // writeback cmov condition
);

   logic        lStepExu;  // step levels only gate the mirror below
   logic        lStepWb;
   instrClass_t lDecode;   // consumed here, nobody downstream needs the class

   ////////////////////////////////////////
   // input capture
   ////////////////////////////////////////

   // the controller changes steps and works after the edge,
   // so everything is sampled once and held for the cycle
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         lStepExu    <= 1'b0;
         lStepWb     <= 1'b0;
         lWorkExu    <= 1'b0;
         lWorkMau    <= 1'b0;
         lWorkWb     <= 1'b0;
         lExuCond    <= 1'b0;
         lMauCond    <= 1'b0;
         lRegA       <= '0;
         lRegB       <= '0;
         lExuDest    <= '0;
         lMauDest    <= '0;
         lExuResData <= '0;
         lMauData    <= '0;
         lDecode     <= opNop;
      end else begin
         lStepExu    <= stepExu;
         lStepWb     <= stepWb;
         lWorkExu    <= workExu;
         lWorkMau    <= workMau;
         lWorkWb     <= workWb;
         lExuCond    <= exuCond;
         lMauCond    <= mauCond;
         lRegA       <= regA;
         lRegB       <= regB;
         lExuDest    <= exuDest;
         lMauDest    <= mauDest;
         lExuResData <= exuResData;
         lMauData    <= mauData;
         lDecode     <= decode;
      end
   end

   ////////////////////////////////////////
   // mirror of the pipe
   ////////////////////////////////////////

   // load flag follows the instruction into execute
   always_ff @(posedge sys_clk) begin
      if (rst)
         exuIsLoad <= 1'b0;
      else if (lStepExu)
         exuIsLoad <= (lDecode == opLoad);  // only loads defer their result
   end

   // writeback entry, memory stage output moves on when wb steps
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         wbAddr <= '0;  // valid bit clear, nothing to write
         wbData <= '0;
         wbCond <= 1'b0;
      end else if (lStepWb) begin
         wbAddr <= lMauDest;
         wbData <= lMauData;
         wbCond <= lMauCond;
      end
   end

endmodule

// ==== rtl/regFile.sv ====
// Register file, two reads one write

module regFile
   import fruPkg::*;
(
   input  logic                     sys_clk,
   input  logic                     rst,
   input  logic [regIndexWidth-1:0] rdIndexA,  // operand A index
   input  logic [regIndexWidth-1:0] rdIndexB,  // operand B index
   input  logic [regAddrWidth-1:0]  wrAddr,    // writeback address, msb valid
   input  logic [dataWidth-1:0]     wrData,    // writeback result
   input  logic                     wrCond,    // cmov passed
   input  logic                     wrWork,    // writeback stage holds work
   output logic [dataWidth-1:0]     readA,
   output logic [dataWidth-1:0]     readB
);

   logic [dataWidth-1:0] regs [regCount];  // the architectural registers
   logic                 wrEn;

   // all three qualifiers needed, a failed cmov leaves the old value
   assign wrEn = wrAddr[regAddrWidth-1] & wrCond & wrWork;

   ////////////////////////////////////////
   // write port
   ////////////////////////////////////////

   // reset clears the whole file in one cycle
   // r31 may be written but the forwarding mux masks it on read
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         for (int i = 0; i < regCount; i++)
            regs[i] <= '0;
      end else if (wrEn) begin
         regs[wrAddr[regIndexWidth-1:0]] <= wrData;
      end
   end

   ////////////////////////////////////////
   // read ports
   ////////////////////////////////////////

   // asynchronous reads, a same-cycle write is covered by wb forwarding
   assign readA = regs[rdIndexA];
   assign readB = regs[rdIndexB];

endmodule

// ==== rtl/operandForward.sv ====
// Operand forwarding and stall detect

module operandForward
   import fruPkg::*;
(
   // registered source addresses, msb is the valid bit
   input  logic [regAddrWidth-1:0] regA,
   input  logic [regAddrWidth-1:0] regB,
   // execute stage
   input  logic [regAddrWidth-1:0] exuDest,
   input  logic [dataWidth-1:0]    exuResData,
   input  logic                    exuCond,
   input  logic                    workExu,
   input  logic                    exuIsLoad,   // result not ready until memory
   // memory stage
   input  logic [regAddrWidth-1:0] mauDest,
   input  logic [dataWidth-1:0]    mauData,
   input  logic                    mauCond,
   input  logic                    workMau,
   // writeback entry
   input  logic [regAddrWidth-1:0] wbAddr,
   input  logic [dataWidth-1:0]    wbData,
   input  logic                    wbCond,
   input  logic                    workWb,
   // register file reads at regA and regB
   input  logic [dataWidth-1:0]    readA,
   input  logic [dataWidth-1:0]    readB,
   // to execute and the pipeline controller
   output logic [dataWidth-1:0]    opd1,
   output logic [dataWidth-1:0]    opd2,
   output logic                    waitForData  // stall request, advisory only
);

   fwdSel_t selA;  // chosen producer for operand A
   fwdSel_t selB;  // chosen producer for operand B
   logic    hazA;  // operand A waits on a load in execute
   logic    hazB;

   ////////////////////////////////////////
   // helper functions
   ////////////////////////////////////////

   // valid source that is not the zero register
   function automatic logic srcLive(input logic [regAddrWidth-1:0] src);
      return src[regAddrWidth-1] && (src[regIndexWidth-1:0] != zeroRegIndex);
   endfunction

   // youngest qualified producer wins, full address compare incl valid bit
   function automatic fwdSel_t pickSource(input logic [regAddrWidth-1:0] src);
      fwdSel_t sel;
      sel = selReg;  // default, nothing in flight
      if (srcLive(src)) begin
         if ((src == exuDest) && !exuIsLoad && exuCond && workExu)
            sel = selExu;
         else if ((src == mauDest) && mauCond && workMau)
            sel = selMau;
         else if ((src == wbAddr) && wbCond && workWb)
            sel = selWb;
      end
      return sel;
   endfunction

   // a load still in execute cannot be forwarded, ask for a stall
   function automatic logic loadHazard(input logic [regAddrWidth-1:0] src);
      return srcLive(src) && (src == exuDest) && exuIsLoad && workExu;
   endfunction

   // operand mux, r31 is substituted regardless of the valid bit
   function automatic logic [dataWidth-1:0] muxOperand(
      input logic [regAddrWidth-1:0] src,
      input fwdSel_t                 sel,
      input logic [dataWidth-1:0]    regData
   );
      logic [dataWidth-1:0] val;
      if (src[regIndexWidth-1:0] == zeroRegIndex) begin
         val = zeroRegValue;
      end else begin
         case (sel)
            selExu:  val = exuResData;
            selMau:  val = mauData;
            selWb:   val = wbData;   // same-cycle write not yet in the file
            default: val = regData;  // selReg
         endcase
      end
      return val;
   endfunction

   ////////////////////////////////////////
   // source selection
   ////////////////////////////////////////

   always_comb begin
      selA = pickSource(regA);
      selB = pickSource(regB);
      hazA = loadHazard(regA);
      hazB = loadHazard(regB);
   end

   ////////////////////////////////////////
   // outputs
   ////////////////////////////////////////

   assign opd1        = muxOperand(regA, selA, readA);
   assign opd2        = muxOperand(regB, selB, readB);
   assign waitForData = hazA | hazB;  // either operand is enough

endmodule

// ==== rtl/fru.sv ====
// Forwarding register unit top

module fru
   import fruPkg::*;
(
   input  logic                    sys_clk,
   input  logic                    rst,
   input  logic                    stepExu,
   input  logic                    stepWb,
   input  logic                    workExu,
   input  logic                    workMau,
   input  logic                    workWb,
   input  logic                    exuCond,
   input  logic                    mauCond,
   input  logic [regAddrWidth-1:0] regA,
   input  logic [regAddrWidth-1:0] regB,
   input  logic [regAddrWidth-1:0] exuDest,
   input  logic [regAddrWidth-1:0] mauDest,
   input  logic [dataWidth-1:0]    exuResData,
   input  logic [dataWidth-1:0]    mauData,
   input  instrClass_t             decode,
   output logic [dataWidth-1:0]    opd1,
   output logic [dataWidth-1:0]    opd2,
   output logic                    waitForData
);

   // registered stage signals
   logic                    lWorkExu;
   logic                    lWorkMau;
   logic                    lWorkWb;
   logic                    lExuCond;
   logic                    lMauCond;
   logic [regAddrWidth-1:0] lRegA;
   logic [regAddrWidth-1:0] lRegB;
   logic [regAddrWidth-1:0] lExuDest;
   logic [regAddrWidth-1:0] lMauDest;
   logic [dataWidth-1:0]    lExuResData;
   logic [dataWidth-1:0]    lMauData;
   // mirror state
   logic                    exuIsLoad;
   logic [regAddrWidth-1:0] wbAddr;
   logic [dataWidth-1:0]    wbData;
   logic                    wbCond;
   // register file reads
   logic [dataWidth-1:0]    readA;
   logic [dataWidth-1:0]    readB;

   ////////////////////////////////////////
   // instances
   ////////////////////////////////////////

   pipeMirror i_mirror (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .stepExu     (stepExu),
      .stepWb      (stepWb),
      .workExu     (workExu),
      .workMau     (workMau),
      .workWb      (workWb),
      .exuCond     (exuCond),
      .mauCond     (mauCond),
      .regA        (regA),
      .regB        (regB),
      .exuDest     (exuDest),
      .mauDest     (mauDest),
      .exuResData  (exuResData),
      .mauData     (mauData),
      .decode      (decode),
      .lWorkExu    (lWorkExu),
      .lWorkMau    (lWorkMau),
      .lWorkWb     (lWorkWb),
      .lExuCond    (lExuCond),
      .lMauCond    (lMauCond),
      .lRegA       (lRegA),
      .lRegB       (lRegB),
      .lExuDest    (lExuDest),
      .lMauDest    (lMauDest),
      .lExuResData (lExuResData),
      .lMauData    (lMauData),
      .exuIsLoad   (exuIsLoad),
      .wbAddr      (wbAddr),
      .wbData      (wbData),
      .wbCond      (wbCond)
   );

   // read at the index bits only, the valid bit matters for forwarding
   regFile i_regFile (
      .sys_clk  (sys_clk),
      .rst      (rst),
      .rdIndexA (lRegA[regIndexWidth-1:0]),
      .rdIndexB (lRegB[regIndexWidth-1:0]),
      .wrAddr   (wbAddr),
      .wrData   (wbData),
      .wrCond   (wbCond),
      .wrWork   (lWorkWb),
      .readA    (readA),
      .readB    (readB)
   );

   operandForward i_forward (
      .regA        (lRegA),
      .regB        (lRegB),
      .exuDest     (lExuDest),
      .exuResData  (lExuResData),
      .exuCond     (lExuCond),
      .workExu     (lWorkExu),
      .exuIsLoad   (exuIsLoad),
      .mauDest     (lMauDest),
      .mauData     (lMauData),
      .mauCond     (lMauCond),
      .workMau     (lWorkMau),
      .wbAddr      (wbAddr),
      .wbData      (wbData),
      .wbCond      (wbCond),
      .workWb      (lWorkWb),
      .readA       (readA),
      .readB       (readB),
      .opd1        (opd1),
      .opd2        (opd2),
      .waitForData (waitForData)
   );

endmodule

// ==== testbench/tbFru.sv ====
// Forwarding register unit testbench

module tbFru
   import fruPkg::*;
();

   localparam string vecPath     = "testbench/fruInput.dat";
   localparam int    maxLines    = 200;  // reading loop gives up past this
   localparam int    resetCycles = 16;

   ////////////////////////////////////////
   // DUT signals
   ////////////////////////////////////////

   logic                    sys_clk    = 1'b0;
   logic                    rst        = 1'b1;  // held from time zero
   logic                    stepExu    = 1'b0;
   logic                    stepWb     = 1'b0;
   logic                    workExu    = 1'b0;
   logic                    workMau    = 1'b0;
   logic                    workWb     = 1'b0;
   logic                    exuCond    = 1'b0;
   logic                    mauCond    = 1'b0;
   logic [regAddrWidth-1:0] regA       = '0;
   logic [regAddrWidth-1:0] regB       = '0;
   logic [regAddrWidth-1:0] exuDest    = '0;
   logic [regAddrWidth-1:0] mauDest    = '0;
   logic [dataWidth-1:0]    exuResData = '0;
   logic [dataWidth-1:0]    mauData    = '0;
   instrClass_t             decode     = opNop;
   logic [dataWidth-1:0]    opd1;
   logic [dataWidth-1:0]    opd2;
   logic                    waitForData;

   // bookkeeping
   int fd;
   int errCount  = 0;  // value mismatches
   int failCount = 0;  // file trouble, timeout
   int vecCount  = 0;

   // one vector as read from the file
   logic                    vStepExu, vStepWb, vWorkExu, vWorkMau, vWorkWb;
   logic                    vExuCond, vMauCond;
   logic [regAddrWidth-1:0] vRegA, vRegB, vExuDest, vMauDest;
   logic [dataWidth-1:0]    vExuResData, vMauData;
   logic [2:0]              vDecode;
   logic [dataWidth-1:0]    expOpd1, expOpd2;
   logic                    expWait;

   // expected values of the vector whose outputs are due after this edge
   logic [dataWidth-1:0]    dueOpd1, dueOpd2;
   logic                    dueWait;
   int                      dueLine;
   bit                      duePending = 1'b0;

   always #2 sys_clk = ~sys_clk;  // period 4

   fru i_dut (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .stepExu     (stepExu),
      .stepWb      (stepWb),
      .workExu     (workExu),
      .workMau     (workMau),
      .workWb      (workWb),
      .exuCond     (exuCond),
      .mauCond     (mauCond),
      .regA        (regA),
      .regB        (regB),
      .exuDest     (exuDest),
      .mauDest     (mauDest),
      .exuResData  (exuResData),
      .mauData     (mauData),
      .decode      (decode),
      .opd1        (opd1),
      .opd2        (opd2),
      .waitForData (waitForData)
   );

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // blank lines and lines starting with # carry no vector
   function automatic bit isSkipLine(input string line);
      int  i;
      bit  skip;
      byte c;
      i = 0;
      while (i < line.len() && (line.getc(i) == 8'h20 || line.getc(i) == 8'h09))
         i++;  // leading spaces and tabs
      if (i >= line.len()) begin
         skip = 1'b1;
      end else begin
         c    = line.getc(i);
         skip = (c == 8'h23) || (c == 8'h0a) || (c == 8'h0d);  // '#', newline, cr
      end
      return skip;
   endfunction

   task driveVector();
      stepExu    <= vStepExu;
      stepWb     <= vStepWb;
      workExu    <= vWorkExu;
      workMau    <= vWorkMau;
      workWb     <= vWorkWb;
      exuCond    <= vExuCond;
      mauCond    <= vMauCond;
      regA       <= vRegA;
      regB       <= vRegB;
      exuDest    <= vExuDest;
      mauDest    <= vMauDest;
      exuResData <= vExuResData;
      mauData    <= vMauData;
      decode     <= instrClass_t'(vDecode);
   endtask

   task checkOutputs();
      if (opd1 !== dueOpd1) begin
         errCount++;
         $display("error at %0t: opd1 expected %h got %h (line %0d)", $time, dueOpd1, opd1,
                  dueLine);
      end
      if (opd2 !== dueOpd2) begin
         errCount++;
         $display("error at %0t: opd2 expected %h got %h (line %0d)", $time, dueOpd2, opd2,
                  dueLine);
      end
      if (waitForData !== dueWait) begin
         errCount++;
         $display("error at %0t: waitForData expected %b got %b (line %0d)", $time, dueWait,
                  waitForData, dueLine);
      end
   endtask

   // vector k goes in at edge k, its outputs are checked just after edge k+1
   task applyFile();
      string line;
      int    lineNo;
      int    fields;
      bit    done;
      lineNo = 0;
      done   = 1'b0;
      while (!done) begin
         if ($fgets(line, fd) == 0) begin
            done = 1'b1;  // end of file
         end else if (lineNo >= maxLines) begin
            $display("timeout: vector file still going after %0d lines", maxLines);
            failCount++;
            done = 1'b1;
         end else begin
            lineNo++;
            if (!isSkipLine(line)) begin
               fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                vStepExu, vStepWb, vWorkExu, vWorkMau, vWorkWb, vExuCond,
                                vMauCond, vRegA, vRegB, vExuDest, vMauDest, vExuResData,
                                vMauData, vDecode, expOpd1, expOpd2, expWait);
               if (fields != 17) begin
                  $display("line %0d of the vector file could not be read", lineNo);
                  failCount++;
               end else begin
                  @(posedge sys_clk);
                  driveVector();
                  if (duePending) begin
                     #1;  // registered outputs settled
                     checkOutputs();
                  end
                  dueOpd1    = expOpd1;
                  dueOpd2    = expOpd2;
                  dueWait    = expWait;
                  dueLine    = lineNo;
                  duePending = 1'b1;
                  vecCount++;
               end
            end
         end
      end
      if (duePending) begin  // last vector still owes its check
         @(posedge sys_clk);
         #1;
         checkOutputs();
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      fd = $fopen(vecPath, "r");
      if (fd == 0) begin
         $display("cannot open %s, no vectors to run", vecPath);
         failCount++;
      end
      repeat (resetCycles) @(posedge sys_clk);
      rst <= 1'b0;
      if (fd != 0) begin
         applyFile();
         $fclose(fd);
         if (vecCount == 0) begin
            $display("the vector file held no vectors");
            failCount++;
         end
      end
      $display("errors: %0d mismatches, %0d other failures, %0d vectors", errCount,
               failCount, vecCount);
      if (errCount == 0 && failCount == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== testbench/fruInput.dat ====
# cols: stepExu stepWb workExu workMau workWb exuCond mauCond regA regB exuDest mauDest
# exuResData mauData decode | expected opd1 opd2 waitForData (address bit 5 = valid)
# reset leaves the file zero
0 0 0 0 0 0 0 21 25 00 00 00000000 00000000 0 00000000 00000000 0
0 0 0 0 0 0 0 2a 3e 00 00 00000000 00000000 0 00000000 00000000 0
# r1 latched into wb, forwarded from wb, then read from the file
0 1 0 0 0 0 1 21 22 00 21 00000000 11111111 0 00000000 00000000 0
0 0 0 0 1 0 0 21 22 00 00 00000000 00000000 0 11111111 00000000 0
0 0 0 0 0 0 0 21 22 00 00 00000000 00000000 0 11111111 00000000 0
# r2 with failed cmov never reaches the file
0 1 0 0 0 0 0 21 22 00 22 00000000 22222222 0 11111111 00000000 0
0 0 0 0 1 0 0 21 22 00 00 00000000 00000000 0 11111111 00000000 0
0 0 0 0 0 0 0 22 21 00 00 00000000 00000000 0 00000000 11111111 0
# r2 and r3 written back to back
0 1 0 0 0 0 1 22 21 00 22 00000000 22220002 0 00000000 11111111 0
0 1 0 0 1 0 1 22 23 00 23 00000000 33330003 0 22220002 00000000 0
0 0 0 0 1 0 0 22 23 00 00 00000000 00000000 0 22220002 33330003 0
0 0 0 0 0 0 0 23 22 00 00 00000000 00000000 0 33330003 22220002 0
# priority on r5, wb latched first, then exu mau wb file
0 1 0 0 0 0 1 25 21 00 25 00000000 5b5b5b5b 0 00000000 11111111 0
0 0 1 1 0 1 1 25 25 25 25 e5e5e5e5 a5a5a5a5 1 e5e5e5e5 e5e5e5e5 0
0 0 0 1 0 1 1 25 25 25 25 e5e5e5e5 a5a5a5a5 1 a5a5a5a5 a5a5a5a5 0
0 0 1 1 0 0 1 25 25 25 25 e5e5e5e5 a5a5a5a5 1 a5a5a5a5 a5a5a5a5 0
0 0 0 1 1 1 0 25 23 25 25 e5e5e5e5 a5a5a5a5 1 5b5b5b5b 33330003 0
0 0 0 0 0 1 1 25 25 25 25 e5e5e5e5 a5a5a5a5 1 5b5b5b5b 5b5b5b5b 0
# r31 reads zero even with live producers
0 0 1 1 0 1 1 3f 3f 3f 3f deadbeef cafef00d 1 00000000 00000000 0
0 0 1 1 0 1 1 1f 3f 3f 3f deadbeef cafef00d 1 00000000 00000000 0
# load enters exu, stalls on either operand, not without work
1 0 0 0 0 0 0 21 22 00 00 00000000 00000000 2 11111111 22220002 0
0 0 1 0 0 1 0 21 22 21 00 77777777 00000000 0 11111111 22220002 1
0 0 1 0 0 1 0 23 21 21 00 77777777 00000000 0 33330003 11111111 1
# store then alu replace the load and forward
1 0 0 0 0 1 0 21 21 21 00 77777777 00000000 3 11111111 11111111 0
1 0 1 0 0 1 0 21 22 21 00 77777777 00000000 1 77777777 22220002 0
0 0 1 0 0 1 0 21 22 22 00 88888888 00000000 0 11111111 88888888 0
# invalid sources read the file and never stall
1 0 0 0 0 0 0 01 02 00 00 00000000 00000000 2 11111111 22220002 0
0 0 1 1 0 1 1 01 21 21 21 99999999 abababab 0 11111111 abababab 1
0 0 1 1 0 1 1 01 01 21 21 99999999 abababab 0 11111111 11111111 0
# load aimed at r31 does not stall
0 0 1 0 0 1 0 3f 22 3f 00 99999999 00000000 0 00000000 22220002 0
0 0 0 0 0 0 0 25 23 00 00 00000000 00000000 0 5b5b5b5b 33330003 0

// ==== filelist.f ====
rtl/fruPkg.sv
rtl/pipeMirror.sv
rtl/regFile.sv
rtl/operandForward.sv
rtl/fru.sv
testbench/tbFru.sv

// ==== Makefile ====
# all of these can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= tbFru
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
